// File: list.f
+incdir+include
src/fpu_pkg.sv
src/fpu_unpack.sv
src/fpu_round_pack.sv
src/fpu_mul.sv
src/fpu_mul_top.sv
test/fpu_mul_checker.sv
test/fpu_mul_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the floating-point multiply testbench with Verilator

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
	-f list.f \
	--top-module fpu_mul_tb \
	--Mdir "$BUILD_DIR" \
	-o fpu_mul_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

"./$BUILD_DIR/fpu_mul_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: test/fpu_mul_tb.sv
`default_nettype none

`timescale 1ns/10ps

module fpu_mul_tb import fpu_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int READY_LIMIT = 100;
	localparam int HOLD_CYCLES = 5;

	typedef struct {
		string name;
		fp32_t op1;
		fp32_t op2;
		fp32_t expected;
	} vector_t;

	logic i_clock;
	logic i_reset;
	logic i_request;
	fp32_t i_op1;
	fp32_t i_op2;
	logic o_ready;
	fp32_t o_result;

	vector_t vectors[$];
	logic vectors_loaded;

	fpu_mul_top dut (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (i_request),
		.i_op1     (i_op1),
		.i_op2     (i_op2),
		.o_ready   (o_ready),
		.o_result  (o_result)
	);

	always #(CLK_PERIOD / 2) i_clock = ~i_clock;

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_result(input string name, input fp32_t expected, input fp32_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_ready(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic add_vector(
		input string name,
		input fp32_t op1,
		input fp32_t op2,
		input fp32_t expected
	);
		vector_t v;
		v.name = name;
		v.op1 = op1;
		v.op2 = op2;
		v.expected = expected;
		vectors.push_back(v);
	endtask

	// expected values worked out by hand, round to nearest even
	task automatic load_vectors();
		add_vector("exact_product", 32'h3FC00000, 32'h40000000, 32'h40400000);
		add_vector("negative_times_positive", 32'hBFC00000, 32'h40000000, 32'hC0400000);
		add_vector("negative_times_negative", 32'hC0000000, 32'hC0400000, 32'h40C00000);
		// guard set with round and sticky clear, odd lsb goes up
		add_vector("tie_odd_rounds_up", 32'h3F800001, 32'h3FC00000, 32'h3FC00002);
		add_vector("tie_even_kept", 32'h3F800003, 32'h3FC00000, 32'h3FC00004);
		add_vector("max_finite_times_one", 32'h7F7FFFFF, 32'h3F800000, 32'h7F7FFFFF);
		add_vector("quiet_nan_operand", 32'h7FC00000, 32'h3F800000, 32'hFFC00000);
		add_vector("signaling_nan_operand", 32'h3F800000, 32'h7F800001, 32'hFFC00000);
		add_vector("inf_times_zero", 32'h7F800000, 32'h00000000, 32'hFFC00000);
		add_vector("neg_zero_times_neg_inf", 32'h80000000, 32'hFF800000, 32'hFFC00000);
		add_vector("neg_inf_times_two", 32'hFF800000, 32'h40000000, 32'hFF800000);
		add_vector("inf_times_neg_denormal", 32'h7F800000, 32'h80000001, 32'hFF800000);
		add_vector("zero_times_negative", 32'h00000000, 32'hC0400000, 32'h80000000);
		add_vector("neg_zero_squared", 32'h80000000, 32'h80000000, 32'h00000000);
		add_vector("denormal_to_min_normal", 32'h00000001, 32'h4B000000, 32'h00800000);
		add_vector("denormal_times_large", 32'h00000001, 32'h7F000000, 32'h34800000);
		add_vector("denormal_result_exact", 32'h3F000000, 32'h00000002, 32'h00000001);
		add_vector("denormal_result_rounded", 32'h3F400000, 32'h00000003, 32'h00000002);
		// 0.75 of the smallest denormal
		add_vector("underflow_rounds_up", 32'h1A400000, 32'h1A000000, 32'h00000001);
		add_vector("underflow_tie_to_zero", 32'h1A000000, 32'h1A000000, 32'h00000000);
		add_vector("underflow_neg_zero", 32'h9A000000, 32'h1A000000, 32'h80000000);
		add_vector("two_deep_denormals", 32'h00000001, 32'h80000001, 32'h80000000);
		add_vector("overflow_positive", 32'h71800000, 32'h71800000, 32'h7F800000);
		add_vector("overflow_negative", 32'hF1800000, 32'h71800000, 32'hFF800000);
		add_vector("max_finite_times_two", 32'h7F7FFFFF, 32'h40000000, 32'h7F800000);
	endtask

	task automatic start_request(input fp32_t op1, input fp32_t op2);
		@(posedge i_clock);
		i_op1 <= op1;
		i_op2 <= op2;
		i_request <= 1'b1;
	endtask

	task automatic release_request();
		@(posedge i_clock);
		i_request <= 1'b0;
	endtask

	// outputs are sampled on the falling edge, away from the DUT's updates
	task automatic wait_for_ready(input logic level, input string name);
		int cycles;
		cycles = 0;
		@(negedge i_clock);
		while (o_ready !== level) begin
			if (cycles >= READY_LIMIT) begin
				$display("%s: o_ready did not reach %b within %0d cycles",
					name, level, READY_LIMIT);
				stop_with_failure();
			end
			cycles++;
			@(negedge i_clock);
		end
	endtask

	task automatic run_vector(input vector_t v);
		start_request(v.op1, v.op2);
		wait_for_ready(1'b1, v.name);
		check_result(v.name, v.expected, o_result);
		release_request();
		wait_for_ready(1'b0, v.name);
	endtask

	initial begin
		int limit;
		wait (vectors_loaded === 1'b1);
		limit = vectors.size() * 100 * CLK_PERIOD;
		#(limit);
		$display("watchdog: the run timed out after %0d ns", limit);
		stop_with_failure();
	end

	initial begin
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_op1 = '0;
		i_op2 = '0;
		vectors_loaded = 1'b0;
		load_vectors();
		vectors_loaded = 1'b1;

		repeat (3) @(posedge i_clock);
		i_reset <= 1'b0;
		@(negedge i_clock);
		check_ready("ready_after_reset", 1'b0, o_ready);

		// special operand, ready two edges after the request is raised
		start_request(32'h7FC00000, 32'h3F800000);
		@(negedge i_clock);
		@(negedge i_clock);
		check_ready("special_latency_early", 1'b0, o_ready);
		@(negedge i_clock);
		check_ready("special_latency", 1'b1, o_ready);
		check_result("special_latency_result", 32'hFFC00000, o_result);
		release_request();
		wait_for_ready(1'b0, "special_latency_release");

		foreach (vectors[i]) begin
			run_vector(vectors[i]);
		end

		// request held past ready
		start_request(32'h3FC00000, 32'h40000000);
		wait_for_ready(1'b1, "hold");
		check_result("hold_first", 32'h40400000, o_result);
		repeat (HOLD_CYCLES) begin
			@(negedge i_clock);
			check_ready("hold_ready", 1'b1, o_ready);
			check_result("hold_result", 32'h40400000, o_result);
		end
		release_request();
		@(negedge i_clock);
		check_ready("release_same_edge", 1'b1, o_ready);
		@(negedge i_clock);
		check_ready("release_next_edge", 1'b0, o_ready);

		add_vector("second_request", 32'h40400000, 32'h40400000, 32'h41100000);
		run_vector(vectors[vectors.size() - 1]);

		if (dut.handshake_checker.reset_violation || dut.handshake_checker.drop_violation ||
			dut.handshake_checker.stability_violation) begin
			$display("a handshake assertion failed during the run");
			stop_with_failure();
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: test/fpu_mul_checker.sv
`default_nettype none

`timescale 1ns/10ps

module fpu_mul_checker import fpu_pkg::*; (
	input logic  i_clock,
	input logic  i_reset,
	input logic  i_request,
	input logic  i_ready,
	input fp32_t i_result
);

	bit reset_violation;
	bit drop_violation;
	bit stability_violation;

	ready_low_after_reset: assert property (@(posedge i_clock) i_reset |=> !i_ready)
	else begin
		reset_violation = 1'b1;
		$error("o_ready was high in the cycle after reset");
	end

	// the result is held for as long as the requester keeps asking
	ready_held_with_request: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_ready && i_request) |=> i_ready)
	else begin
		drop_violation = 1'b1;
		$error("o_ready fell while i_request was still high");
	end

	result_stable_while_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		i_ready |=> (!i_ready || $stable(i_result)))
	else begin
		stability_violation = 1'b1;
		$error("o_result changed while o_ready stayed high");
	end

endmodule

bind fpu_mul_top fpu_mul_checker handshake_checker (
	.i_clock   (i_clock),
	.i_reset   (i_reset),
	.i_request (i_request),
	.i_ready   (o_ready),
	.i_result  (o_result)
);

`default_nettype wire

// File: src/fpu_mul_top.sv
`default_nettype none

`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpu_mul_top import fpu_pkg::*; (
	input  logic  i_clock,
	input  logic  i_reset,
	input  logic  i_request,
	input  fp32_t i_op1,
	input  fp32_t i_op2,
	output logic  o_ready,
	output fp32_t o_result
);

	fp_unpacked_t op1_unpacked;
	fp_unpacked_t op2_unpacked;

	fpu_unpack u_unpack_op1 (
		.i_value   (i_op1),
		.o_operand (op1_unpacked)
	);

	fpu_unpack u_unpack_op2 (
		.i_value   (i_op2),
		.o_operand (op2_unpacked)
	);

	fpu_mul u_mul (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (i_request),
		.i_a       (op1_unpacked),
		.i_b       (op2_unpacked),
		.o_ready   (o_ready),
		.o_result  (o_result)
	);

endmodule

`default_nettype wire

// File: src/fpu_mul.sv
`default_nettype none

`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpu_mul import fpu_pkg::*; (
	input  logic         i_clock,
	input  logic         i_reset,
	input  logic         i_request,
	input  fp_unpacked_t i_a,
	input  fp_unpacked_t i_b,
	output logic         o_ready,
	output fp32_t        o_result
);

	localparam int PROD_W = 2 * `FPU_MANT_W;
	localparam logic signed [`FPU_IEXP_W-1:0] EXP_ONE = 1;
	localparam logic signed [`FPU_IEXP_W-1:0] EXP_MIN = 1 - `FPU_EXP_BIAS;
	// below this every mantissa bit lands under the round position
	localparam logic signed [`FPU_IEXP_W-1:0] EXP_FLUSH = EXP_MIN - (`FPU_MANT_W + 1);
	localparam fp32_t QNAN = '{
		sign: 1'b1,
		exponent: '1,
		fraction: {1'b1, {(`FPU_FRAC_W-1){1'b0}}}
	};

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_SPECIAL,
		ST_NORM_A,
		ST_NORM_B,
		ST_MULTIPLY,
		ST_SPLIT,
		ST_NORM_RESULT,
		ST_UNDERFLOW,
		ST_ROUND,
		ST_HOLD
	} state_e;

	state_e state;

	fp_unpacked_t a_op;
	fp_unpacked_t b_op;
	logic [PROD_W-1:0] product;
	logic signed [`FPU_IEXP_W-1:0] z_e;
	logic [`FPU_MANT_W-1:0] z_m;
	fp_grs_t grs;
	fp32_t rp_value;

	logic sign_xor;
	logic a_nan, b_nan;
	logic a_inf, b_inf;
	logic a_zero, b_zero;

	assign sign_xor = a_op.sign ^ b_op.sign;
	assign a_nan = (a_op.op_class == FP_NAN);
	assign b_nan = (b_op.op_class == FP_NAN);
	assign a_inf = (a_op.op_class == FP_INF);
	assign b_inf = (b_op.op_class == FP_INF);
	assign a_zero = (a_op.op_class == FP_ZERO);
	assign b_zero = (b_op.op_class == FP_ZERO);

	fpu_round_pack u_round_pack (
		.i_sign     (sign_xor),
		.i_exponent (z_e),
		.i_mantissa (z_m),
		.i_grs      (grs),
		.o_value    (rp_value)
	);

	always_ff @(posedge i_clock) begin
		case (state)
			ST_IDLE: begin
				o_ready <= 1'b0;
				if (i_request) begin
					a_op <= i_a;
					b_op <= i_b;
					state <= ST_SPECIAL;
				end
			end

			ST_SPECIAL: begin
				if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf)) begin
					o_result <= QNAN;
					o_ready <= 1'b1;
					state <= ST_HOLD;
				end else if (a_inf || b_inf) begin
					o_result <= '{sign: sign_xor, exponent: '1, fraction: '0};
					o_ready <= 1'b1;
					state <= ST_HOLD;
				end else if (a_zero || b_zero) begin
					o_result <= '{sign: sign_xor, exponent: '0, fraction: '0};
					o_ready <= 1'b1;
					state <= ST_HOLD;
				end else begin
					state <= ST_NORM_A;
				end
			end

			// denormals enter with the hidden bit clear
			ST_NORM_A: begin
				if (a_op.mantissa[`FPU_MANT_W-1]) begin
					state <= ST_NORM_B;
				end else begin
					a_op.mantissa <= a_op.mantissa << 1;
					a_op.exponent <= a_op.exponent - EXP_ONE;
				end
			end

			ST_NORM_B: begin
				if (b_op.mantissa[`FPU_MANT_W-1]) begin
					state <= ST_MULTIPLY;
				end else begin
					b_op.mantissa <= b_op.mantissa << 1;
					b_op.exponent <= b_op.exponent - EXP_ONE;
				end
			end

			ST_MULTIPLY: begin
				product <= a_op.mantissa * b_op.mantissa;
				z_e <= a_op.exponent + b_op.exponent + EXP_ONE;
				state <= ST_SPLIT;
			end

			ST_SPLIT: begin
				z_m <= product[PROD_W-1:`FPU_MANT_W];
				grs.guard <= product[`FPU_MANT_W-1];
				grs.round <= product[`FPU_MANT_W-2];
				grs.sticky <= |product[`FPU_MANT_W-3:0];
				state <= ST_NORM_RESULT;
			end

			// at most one step, both mantissas are normalized
			ST_NORM_RESULT: begin
				if (!z_m[`FPU_MANT_W-1]) begin
					z_e <= z_e - EXP_ONE;
					z_m <= {z_m[`FPU_MANT_W-2:0], grs.guard};
					grs.guard <= grs.round;
					grs.round <= 1'b0;
				end else begin
					state <= ST_UNDERFLOW;
				end
			end

			ST_UNDERFLOW: begin
				if (z_e < EXP_FLUSH) begin
					// whole mantissa ends up in sticky, skip the slow walk
					grs <= '{
						guard: 1'b0,
						round: 1'b0,
						sticky: grs.sticky | grs.round | grs.guard | (|z_m)
					};
					z_m <= '0;
					z_e <= EXP_MIN;
				end else if (z_e < EXP_MIN) begin
					z_e <= z_e + EXP_ONE;
					z_m <= z_m >> 1;
					grs.guard <= z_m[0];
					grs.round <= grs.guard;
					grs.sticky <= grs.sticky | grs.round;
				end else begin
					state <= ST_ROUND;
				end
			end

			ST_ROUND: begin
				o_result <= rp_value;
				o_ready <= 1'b1;
				state <= ST_HOLD;
			end

			// result held until the requester lets go
			ST_HOLD: begin
				if (!i_request) begin
					o_ready <= 1'b0;
					state <= ST_IDLE;
				end
			end

			default: begin
				state <= ST_IDLE;
			end
		endcase

		if (i_reset) begin
			o_ready <= 1'b0;
			state <= ST_IDLE;
		end
	end

endmodule

`default_nettype wire

// File: src/fpu_round_pack.sv
`default_nettype none

`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpu_round_pack import fpu_pkg::*; (
	input  logic                          i_sign,
	input  logic signed [`FPU_IEXP_W-1:0] i_exponent,
	input  logic [`FPU_MANT_W-1:0]        i_mantissa,
	input  fp_grs_t                       i_grs,
	output fp32_t                         o_value
);

	// bias doubles as the largest finite exponent
	localparam logic signed [`FPU_IEXP_W-1:0] EXP_BIAS = `FPU_EXP_BIAS;
	localparam logic signed [`FPU_IEXP_W-1:0] EXP_MIN = 1 - `FPU_EXP_BIAS;
	localparam logic signed [`FPU_IEXP_W-1:0] EXP_ONE = 1;

	logic round_up;
	logic [`FPU_MANT_W:0] increment;
	logic [`FPU_MANT_W:0] sum;
	logic [`FPU_MANT_W-1:0] mant_r;
	logic signed [`FPU_IEXP_W-1:0] exp_r;
	logic signed [`FPU_IEXP_W-1:0] exp_biased;

	// nearest even: ties go up only when the low bit is odd
	assign round_up = i_grs.guard & (i_grs.round | i_grs.sticky | i_mantissa[0]);
	assign increment = {{`FPU_MANT_W{1'b0}}, round_up};
	assign sum = {1'b0, i_mantissa} + increment;

	always_comb begin
		if (sum[`FPU_MANT_W]) begin
			// carry out leaves 1.0, one binade up
			mant_r = sum[`FPU_MANT_W:1];
			exp_r = i_exponent + EXP_ONE;
		end else begin
			mant_r = sum[`FPU_MANT_W-1:0];
			exp_r = i_exponent;
		end
	end

	assign exp_biased = exp_r + EXP_BIAS;

	always_comb begin
		o_value.sign = i_sign;
		o_value.exponent = exp_biased[`FPU_EXP_W-1:0];
		o_value.fraction = mant_r[`FPU_FRAC_W-1:0];

		if (exp_r > EXP_BIAS) begin
			o_value.exponent = '1;
			o_value.fraction = '0;
		end else if ((exp_r == EXP_MIN) && !mant_r[`FPU_MANT_W-1]) begin
			// denormal or zero
			o_value.exponent = '0;
		end
	end

endmodule

`default_nettype wire

// File: src/fpu_unpack.sv
`default_nettype none

`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpu_unpack import fpu_pkg::*; (
	input  fp32_t        i_value,
	output fp_unpacked_t o_operand
);

	localparam logic signed [`FPU_IEXP_W-1:0] EXP_BIAS = `FPU_EXP_BIAS;
	localparam logic signed [`FPU_IEXP_W-1:0] EXP_MIN = 1 - `FPU_EXP_BIAS;

	logic signed [`FPU_IEXP_W-1:0] unbiased;

	assign unbiased = $signed({{(`FPU_IEXP_W-`FPU_EXP_W){1'b0}}, i_value.exponent}) - EXP_BIAS;

	always_comb begin
		o_operand.sign = i_value.sign;
		o_operand.exponent = unbiased;
		o_operand.mantissa = {1'b1, i_value.fraction};
		o_operand.op_class = FP_NORMAL;

		if (i_value.exponent == '0) begin
			// no hidden bit for zero and denormals
			o_operand.mantissa = {1'b0, i_value.fraction};
			if (i_value.fraction == '0) begin
				o_operand.op_class = FP_ZERO;
			end else begin
				o_operand.op_class = FP_DENORM;
				o_operand.exponent = EXP_MIN;
			end
		end else if (i_value.exponent == '1) begin
			if (i_value.fraction == '0) begin
				o_operand.op_class = FP_INF;
			end else begin
				o_operand.op_class = FP_NAN;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/fpu_pkg.sv
`default_nettype none

`include "fpu_defs.svh"

package fpu_pkg;

	typedef struct packed {
		logic sign;
		logic [`FPU_EXP_W-1:0] exponent;
		logic [`FPU_FRAC_W-1:0] fraction;
	} fp32_t;

	typedef enum logic [2:0] {
		FP_ZERO,
		FP_DENORM,
		FP_NORMAL,
		FP_INF,
		FP_NAN
	} fp_class_e;

	// exponent is unbiased; a denormal is carried at the minimum
	// exponent with its hidden bit clear
	typedef struct packed {
		logic sign;
		logic signed [`FPU_IEXP_W-1:0] exponent;
		logic [`FPU_MANT_W-1:0] mantissa;
		fp_class_e op_class;
	} fp_unpacked_t;

	typedef struct packed {
		logic guard;
		logic round;
		logic sticky;
	} fp_grs_t;

endpackage

`default_nettype wire

// File: include/fpu_defs.svh
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// binary32 field widths
`define FPU_FRAC_W 23
`define FPU_EXP_W 8

// fraction plus the hidden bit
`define FPU_MANT_W 24

// signed exponent inside the datapath, wide enough for the sum
// of two normalized denormal exponents
`define FPU_IEXP_W 10

`define FPU_EXP_BIAS 127

`endif
